// ==== agu_defines.svh ====
// AGU global widths and adder pipeline depth
// Shared by the package and the RTL modules
`ifndef AGU_DEFINES_SVH
`define AGU_DEFINES_SVH

// Byte address width of every generated address
`define AGU_ADDR_W 32

// Width of bounds, strides and loop indices
`define AGU_CNT_W 16

// Register stages in the address adder
// The adder has no FIFO and no skid buffer
`define AGU_SUM_DEPTH 2

`endif

// ==== agu_pkg.sv ====
// AGU shared types
// Address and count words, command opcodes and controller states
`include "agu_defines.svh"

package agu_pkg;

    typedef logic [`AGU_ADDR_W-1:0] addr_t;
    typedef logic [`AGU_CNT_W-1:0]  cnt_t;

    // Command opcodes driven by software
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_START = 2'd1,
        CMD_ABORT = 2'd2
    } agu_cmd_e;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2
    } agu_state_e;

endpackage

// ==== agu_if.sv ====
// AGU internal buses
// Latched configuration and the offset tuple stream

interface agu_cfg_if import agu_pkg::*; ();

    // Base address of the whole walk
    addr_t base;
    // Per-loop strides in bytes
    cnt_t  stride0;
    cnt_t  stride1;
    cnt_t  stride2;
    // Per-loop trip counts, never zero
    cnt_t  bound0;
    cnt_t  bound1;
    cnt_t  bound2;

    modport ctrl (output base, stride0, stride1, stride2, bound0, bound1, bound2);
    modport nest (input stride0, stride1, stride2, bound0, bound1, bound2);
    modport sum  (input base);

endinterface

interface agu_off_if import agu_pkg::*; ();

    logic  valid;
    // One offset per loop level
    addr_t off0;
    addr_t off1;
    addr_t off2;
    // Final tuple of the loop nest
    logic  last;

    modport nest (output valid, off0, off1, off2, last);
    modport sum  (input valid, off0, off1, off2, last);

endinterface

// ==== lib_counter.sv ====
// Generic counter with clear, load, stepped enable and wrap to init
// Terminal count flags the max value
`include "agu_defines.svh"

module lib_counter #(
    parameter int WIDTH = `AGU_CNT_W
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             clear_i,
    input  logic             en_i,
    input  logic             load_i,
    input  logic [WIDTH-1:0] step_i,
    input  logic [WIDTH-1:0] init_i,
    input  logic [WIDTH-1:0] max_i,
    input  logic [WIDTH-1:0] d_i,
    output logic [WIDTH-1:0] count_o,
    output logic             tc_o
);

    logic [WIDTH-1:0] count_q;
    logic [WIDTH-1:0] count_d;

    // Next value
    // Load wins over enable so a wrap can be forced from outside
    always_comb begin
        count_d = count_q;
        if (load_i) begin
            count_d = d_i;
        end else if (en_i) begin
            if (tc_o) begin
                count_d = init_i;
            end else begin
                count_d = count_q + step_i;
            end
        end
    end

    // Reset and clear both return to init
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            count_q <= init_i;
        end else begin
            count_q <= count_d;
        end
    end

    assign tc_o    = (count_q == max_i);
    assign count_o = count_q;

endmodule

// ==== agu_loop_nest.sv ====
// Three-level loop nest walker
// Index counters chained by terminal count, each paired with an offset accumulator
`include "agu_defines.svh"

module agu_loop_nest import agu_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   step_en_i,
    input  logic   restart_i,
    input  logic   stall_i,
    agu_cfg_if.nest cfg,
    agu_off_if.nest off
);

    cnt_t       stride_w [3];
    cnt_t       bound_m1 [3];
    cnt_t       idx      [3];
    addr_t      acc      [3];
    logic [2:0] idx_tc;
    logic [2:0] idx_en;
    logic       all_tc;

    // Registered tuple
    logic       valid_q;
    logic       last_q;
    addr_t      off_q    [3];

    // Flatten the configuration so the loops can be generated
    assign stride_w[0] = cfg.stride0;
    assign stride_w[1] = cfg.stride1;
    assign stride_w[2] = cfg.stride2;
    assign bound_m1[0] = cfg.bound0 - cnt_t'(1);
    assign bound_m1[1] = cfg.bound1 - cnt_t'(1);
    assign bound_m1[2] = cfg.bound2 - cnt_t'(1);

    // Loop 0 is innermost
    // An outer loop steps only when every inner loop wraps
    assign idx_en[0] = step_en_i;
    assign idx_en[1] = step_en_i & idx_tc[0];
    assign idx_en[2] = step_en_i & idx_tc[0] & idx_tc[1];
    assign all_tc    = &idx_tc;

    for (genvar i = 0; i < 3; i++) begin : g_loop
        // Index counter, wraps at bound minus one
        lib_counter #(.WIDTH(`AGU_CNT_W)) u_idx (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .clear_i (restart_i),
            .en_i    (idx_en[i]),
            .load_i  (1'b0),
            .step_i  (cnt_t'(1)),
            .init_i  ('0),
            .max_i   (bound_m1[i]),
            .d_i     ('0),
            .count_o (idx[i]),
            .tc_o    (idx_tc[i])
        );

        // Offset accumulator, zeroed when its index wraps
        // Offsets stay below all ones, so its own terminal count never fires
        lib_counter #(.WIDTH(`AGU_ADDR_W)) u_acc (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .clear_i (restart_i),
            .en_i    (idx_en[i]),
            .load_i  (idx_en[i] & idx_tc[i]),
            .step_i  (addr_t'(stride_w[i])),
            .init_i  ('0),
            .max_i   ('1),
            .d_i     ('0),
            .count_o (acc[i]),
            .tc_o    ()
        );

        // The controller only steps with a latched, legal configuration
        a_idx_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
            step_en_i |-> idx[i] <= bound_m1[i])
            else $error("loop %0d index beyond its bound", i);
    end

    // Tuple valid and last, held under stall
    always_ff @(posedge clk_i) begin
        if (reset_i || restart_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= step_en_i;
            last_q  <= step_en_i & all_tc;
        end
    end

    // Offset payload, captured on a step only
    always_ff @(posedge clk_i) begin
        if (!stall_i && step_en_i) begin
            off_q <= acc;
        end
    end

    assign off.valid = valid_q;
    assign off.last  = last_q;
    assign off.off0  = off_q[0];
    assign off.off1  = off_q[1];
    assign off.off2  = off_q[2];

endmodule

// ==== agu_addr_sum.sv ====
// Two-stage address adder
// Base plus three offsets, with valid and last carried alongside
`include "agu_defines.svh"

module agu_addr_sum import agu_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  flush_i,
    input  logic  stall_i,
    agu_cfg_if.sum cfg,
    agu_off_if.sum off,
    output addr_t addr_o,
    output logic  valid_o,
    output logic  last_out_o
);

    localparam int DEPTH = `AGU_SUM_DEPTH;

    logic [DEPTH-1:0] vld_q;
    logic [DEPTH-1:0] last_q;
    addr_t            sum_a_q;
    addr_t            sum_b_q;
    addr_t            addr_q;

    // Side-band shift, flush beats stall
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            vld_q  <= '0;
            last_q <= '0;
        end else if (!stall_i) begin
            vld_q  <= {vld_q[DEPTH-2:0], off.valid};
            last_q <= {last_q[DEPTH-2:0], off.last};
        end
    end

    // Stage 1 splits the sum in two halves
    always_ff @(posedge clk_i) begin
        if (!stall_i && off.valid) begin
            sum_a_q <= cfg.base + off.off0;
            sum_b_q <= off.off1 + off.off2;
        end
    end

    // Stage 2, wraps modulo the address width
    // Holds the last address when nothing new arrives
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            addr_q <= '0;
        end else if (!stall_i && vld_q[0]) begin
            addr_q <= sum_a_q + sum_b_q;
        end
    end

    assign addr_o     = addr_q;
    assign valid_o    = vld_q[DEPTH-1];
    assign last_out_o = last_q[DEPTH-1];

    // The nest only marks last on a valid tuple
    a_last_with_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(last_out_o) |-> valid_o)
        else $error("last left the adder without a valid address");

endmodule

// ==== agu_ctrl.sv ====
// AGU controller
// Decodes commands, latches the configuration and tracks the run to completion

module agu_ctrl import agu_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     stall_i,
    input  agu_cmd_e cmd_i,
    input  addr_t    base_i,
    input  cnt_t     stride0_i,
    input  cnt_t     stride1_i,
    input  cnt_t     stride2_i,
    input  cnt_t     bound0_i,
    input  cnt_t     bound1_i,
    input  cnt_t     bound2_i,
    agu_cfg_if.ctrl  cfg,
    output logic     step_en_o,
    output logic     restart_o,
    output logic     flush_o,
    input  logic     last_i,
    input  logic     last_out_i,
    output logic     busy_o,
    output logic     done_o
);

    agu_state_e state_q;
    agu_state_e state_d;
    logic       start_acc;
    logic       abort_acc;
    logic       done_q;

    // Start only from idle, abort only while busy
    assign start_acc = (state_q == ST_IDLE) && (cmd_i == CMD_START);
    assign abort_acc = (state_q != ST_IDLE) && (cmd_i == CMD_ABORT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_acc) state_d = ST_RUN;
            end
            ST_RUN: begin
                if (abort_acc) state_d = ST_IDLE;
                else if (!stall_i && last_i) state_d = ST_DRAIN;
            end
            ST_DRAIN: begin
                if (abort_acc) state_d = ST_IDLE;
                else if (!stall_i && last_out_i) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Final address seen unstalled
            done_q  <= (state_q == ST_DRAIN) && last_out_i && !stall_i && !abort_acc;
        end
    end

    // Configuration is sampled on the accepted start only
    always_ff @(posedge clk_i) begin
        if (start_acc) begin
            cfg.base    <= base_i;
            cfg.stride0 <= stride0_i;
            cfg.stride1 <= stride1_i;
            cfg.stride2 <= stride2_i;
            cfg.bound0  <= bound0_i;
            cfg.bound1  <= bound1_i;
            cfg.bound2  <= bound2_i;
        end
    end

    // Stop stepping once the final tuple is out of the nest
    assign step_en_o = (state_q == ST_RUN) && !stall_i && !last_i && !abort_acc;
    // Abort also restarts the nest so no stale tuple survives a stall
    assign restart_o = start_acc || abort_acc;
    assign flush_o   = abort_acc;
    assign busy_o    = (state_q != ST_IDLE);
    assign done_o    = done_q;

    a_bounds_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
        start_acc |-> (bound0_i != '0) && (bound1_i != '0) && (bound2_i != '0))
        else $error("start issued with a zero loop bound");

    // An aborted run returns to idle without completion
    a_abort_no_done: assert property (@(posedge clk_i) disable iff (reset_i)
        abort_acc |=> !done_o && (state_q == ST_IDLE))
        else $error("done pulsed on an aborted run");

endmodule

// ==== agu_top.sv ====
// Strided address generator top level
// Controller, loop nest and address adder behind plain ports

module agu_top import agu_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  agu_cmd_e cmd_i,
    input  addr_t    base_i,
    input  cnt_t     stride0_i,
    input  cnt_t     stride1_i,
    input  cnt_t     stride2_i,
    input  cnt_t     bound0_i,
    input  cnt_t     bound1_i,
    input  cnt_t     bound2_i,
    input  logic     stall_i,
    output addr_t    addr_o,
    output logic     addr_valid_o,
    output logic     busy_o,
    output logic     done_o
);

    logic step_en;
    logic restart;
    logic flush;
    logic last_out;

    agu_cfg_if u_cfg_if ();
    agu_off_if u_off_if ();

    agu_ctrl u_agu_ctrl (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .stall_i    (stall_i),
        .cmd_i      (cmd_i),
        .base_i     (base_i),
        .stride0_i  (stride0_i),
        .stride1_i  (stride1_i),
        .stride2_i  (stride2_i),
        .bound0_i   (bound0_i),
        .bound1_i   (bound1_i),
        .bound2_i   (bound2_i),
        .cfg        (u_cfg_if.ctrl),
        .step_en_o  (step_en),
        .restart_o  (restart),
        .flush_o    (flush),
        // Last tuple leaving the nest
        .last_i     (u_off_if.last),
        .last_out_i (last_out),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    agu_loop_nest u_agu_loop_nest (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .step_en_i (step_en),
        .restart_i (restart),
        .stall_i   (stall_i),
        .cfg       (u_cfg_if.nest),
        .off       (u_off_if.nest)
    );

    agu_addr_sum u_agu_addr_sum (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (flush),
        .stall_i    (stall_i),
        .cfg        (u_cfg_if.sum),
        .off        (u_off_if.sum),
        .addr_o     (addr_o),
        .valid_o    (addr_valid_o),
        .last_out_o (last_out)
    );

endmodule

// ==== tb_agu.sv ====
// Testbench for the strided address generator
// Reads walks from a data file, models the loop nest and checks every address
module tb_agu import agu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REC_W    = 10;
    localparam int TEST_MAX = 32;

    logic     clk_i = 1'b0;
    logic     reset_i;
    agu_cmd_e cmd_i;
    addr_t    base_i;
    cnt_t     stride0_i;
    cnt_t     stride1_i;
    cnt_t     stride2_i;
    cnt_t     bound0_i;
    cnt_t     bound1_i;
    cnt_t     bound2_i;
    logic     stall_i;
    addr_t    addr_o;
    logic     addr_valid_o;
    logic     busy_o;
    logic     done_o;

    // One record of REC_W words per test line
    logic [31:0] tests_mem [TEST_MAX * REC_W];
    addr_t       exp_q [$];

    // Configuration of the current test
    addr_t       cfg_base;
    cnt_t        cfg_s0;
    cnt_t        cfg_s1;
    cnt_t        cfg_s2;
    cnt_t        cfg_b0;
    cnt_t        cfg_b1;
    cnt_t        cfg_b2;
    int unsigned stall_chance;

    int          err_count   = 0;
    int          check_total = 0;
    int          test_count  = 0;
    logic        timed_out   = 1'b0;

    always #5 clk_i = ~clk_i;

    agu_top u_agu_top (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cmd_i        (cmd_i),
        .base_i       (base_i),
        .stride0_i    (stride0_i),
        .stride1_i    (stride1_i),
        .stride2_i    (stride2_i),
        .bound0_i     (bound0_i),
        .bound1_i     (bound1_i),
        .bound2_i     (bound2_i),
        .stall_i      (stall_i),
        .addr_o       (addr_o),
        .addr_valid_o (addr_valid_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t: test %0d %s got %h expected %h",
                     $time, test_count, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t: test %0d %s got %b expected %b",
                     $time, test_count, what, got, exp);
        end
    endtask

    task automatic check_count(input cnt_t got, input cnt_t exp, input string what);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t: test %0d %s got %0d expected %0d",
                     $time, test_count, what, got, exp);
        end
    endtask

    // Stall chance is given in 256ths
    function automatic logic pick_stall();
        return ($urandom() & 32'hff) < stall_chance;
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            2:       return "abort";
            3:       return "start while busy";
            default: return "walk";
        endcase
    endfunction

    // Nested-loop rule, loop 0 innermost, all sums modulo the address width
    task automatic build_expected();
        int i0;
        int i1;
        int i2;
        exp_q.delete();
        for (i2 = 0; i2 < int'(cfg_b2); i2++) begin
            for (i1 = 0; i1 < int'(cfg_b1); i1++) begin
                for (i0 = 0; i0 < int'(cfg_b0); i0++) begin
                    exp_q.push_back(cfg_base + addr_t'(i0) * addr_t'(cfg_s0)
                                    + addr_t'(i1) * addr_t'(cfg_s1)
                                    + addr_t'(i2) * addr_t'(cfg_s2));
                end
            end
        end
    endtask

    // Drive on the rising edge, then observe at the falling edge
    task automatic step_cycle(input agu_cmd_e cmd, input logic stall);
        @(posedge clk_i);
        cmd_i   <= cmd;
        stall_i <= stall;
        @(negedge clk_i);
    endtask

    task automatic drive_config(input agu_cmd_e cmd, input logic stall, input addr_t base,
                                input cnt_t s0, s1, s2, b0, b1, b2);
        @(posedge clk_i);
        cmd_i     <= cmd;
        stall_i   <= stall;
        base_i    <= base;
        stride0_i <= s0;
        stride1_i <= s1;
        stride2_i <= s2;
        bound0_i  <= b0;
        bound1_i  <= b1;
        bound2_i  <= b2;
        @(negedge clk_i);
    endtask

    // One start, then cycles until done, abort or timeout
    task automatic run_walk(input int kind, input int event_cyc);
        int       n;
        int       cyc;
        int       limit;
        int       last_cyc;
        logic     finished;
        logic     done_exp;
        logic     stall;
        logic     prev_stall;
        logic     prev_valid;
        addr_t    prev_addr;
        agu_cmd_e cmd;
        n        = 0;
        cyc      = 0;
        last_cyc = -1;
        finished = 1'b0;
        limit    = 64 + 16 * exp_q.size();
        drive_config(CMD_START, 1'b0, cfg_base, cfg_s0, cfg_s1, cfg_s2, cfg_b0, cfg_b1, cfg_b2);
        prev_stall = 1'b0;
        prev_valid = addr_valid_o;
        prev_addr  = addr_o;
        while (!finished && !timed_out) begin
            cyc++;
            cmd = CMD_NONE;
            if (kind == 2 && cyc == event_cyc) begin
                cmd = CMD_ABORT;
            end
            stall = pick_stall();
            // Second start carries a different configuration that must be ignored
            if (kind == 3 && cyc == event_cyc) begin
                drive_config(CMD_START, stall, ~cfg_base, cfg_s0 + cnt_t'(1), cfg_s1 + cnt_t'(1),
                             cfg_s2 + cnt_t'(1), cfg_b0 + cnt_t'(1), cfg_b1, cfg_b2);
            end else begin
                step_cycle(cmd, stall);
            end
            if (kind == 2 && cyc == event_cyc + 1) begin
                check_flag(busy_o, 1'b0, "busy_o after abort");
                check_flag(addr_valid_o, 1'b0, "addr_valid_o after abort");
                check_flag(done_o, 1'b0, "done_o after abort");
                finished = 1'b1;
            end else begin
                // The run ends in the cycle after the final address is taken
                done_exp = (n == exp_q.size()) && (last_cyc == cyc - 1);
                if (prev_stall) begin
                    check_addr(addr_o, prev_addr, "addr_o held under stall");
                    check_flag(addr_valid_o, prev_valid, "addr_valid_o held under stall");
                end
                check_flag(busy_o, !done_exp, "busy_o during run");
                check_flag(done_o, done_exp, "done_o after final address");
                // An address is taken in a cycle where it is valid and not stalled
                if (addr_valid_o && !stall) begin
                    if (n == 0 && stall_chance == 0) begin
                        check_count(cnt_t'(cyc - 1), cnt_t'(3), "start latency");
                    end
                    if (n < exp_q.size()) begin
                        check_addr(addr_o, exp_q[n], $sformatf("address %0d", n));
                    end else begin
                        check_count(cnt_t'(n + 1), cnt_t'(exp_q.size()), "address count");
                    end
                    n++;
                    last_cyc = cyc;
                end
                if (done_exp || done_o) begin
                    check_count(cnt_t'(n), cnt_t'(exp_q.size()), "address count");
                    finished = 1'b1;
                end
            end
            if (!finished && cyc > limit) begin
                $display("Timeout: test %0d saw no done_o within %0d cycles", test_count, limit);
                timed_out = 1'b1;
            end
            prev_stall = stall;
            prev_valid = addr_valid_o;
            prev_addr  = addr_o;
        end
    endtask

    // No stray address, done pulse or busy after a run ends
    task automatic idle_check(input int cycles);
        int k;
        for (k = 0; k < cycles; k++) begin
            step_cycle(CMD_NONE, 1'b0);
            check_flag(addr_valid_o, 1'b0, "addr_valid_o while idle");
            check_flag(done_o, 1'b0, "done_o while idle");
            check_flag(busy_o, 1'b0, "busy_o while idle");
        end
    endtask

    initial begin
        int rec;
        int idx;
        int kind;
        int event_cyc;
        int err_before;
        void'($urandom(32'h68ab26ab));
        reset_i   <= 1'b1;
        cmd_i     <= CMD_NONE;
        base_i    <= '0;
        stride0_i <= '0;
        stride1_i <= '0;
        stride2_i <= '0;
        bound0_i  <= cnt_t'(1);
        bound1_i  <= cnt_t'(1);
        bound2_i  <= cnt_t'(1);
        stall_i   <= 1'b0;
        // Unused records stay zero and end the list
        for (rec = 0; rec < TEST_MAX * REC_W; rec++) begin
            tests_mem[rec] = '0;
        end
        $readmemh("agu_tests.txt", tests_mem);

        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_addr(addr_o, '0, "addr_o after reset");
        check_flag(addr_valid_o, 1'b0, "addr_valid_o after reset");
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(done_o, 1'b0, "done_o after reset");
        $display("test %0d reset: %0d errors", test_count, err_count);

        rec = 0;
        while (!timed_out && rec < TEST_MAX && tests_mem[rec * REC_W] != 0) begin
            idx          = rec * REC_W;
            kind         = int'(tests_mem[idx]);
            cfg_base     = tests_mem[idx + 1];
            cfg_s0       = tests_mem[idx + 2][15:0];
            cfg_s1       = tests_mem[idx + 3][15:0];
            cfg_s2       = tests_mem[idx + 4][15:0];
            cfg_b0       = tests_mem[idx + 5][15:0];
            cfg_b1       = tests_mem[idx + 6][15:0];
            cfg_b2       = tests_mem[idx + 7][15:0];
            stall_chance = tests_mem[idx + 8];
            event_cyc    = int'(tests_mem[idx + 9]);
            test_count++;
            err_before = err_count;
            build_expected();
            run_walk(kind, event_cyc);
            if (!timed_out) begin
                idle_check(8);
            end
            // A fresh start after an abort must walk the whole nest again
            if (kind == 2 && !timed_out) begin
                run_walk(1, 0);
                if (!timed_out) begin
                    idle_check(8);
                end
            end
            $display("test %0d %s: %0d addresses, %0d errors", test_count, kind_name(kind),
                     exp_q.size(), err_count - err_before);
            rec++;
        end

        $display("tests %0d, checks %0d, errors %0d", test_count, check_total, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== agu_tests.txt ====
// kind base stride0 stride1 stride2 bound0 bound1 bound2 stall cycle, all hex
// kind 1 walk, 2 abort at cycle, 3 second start at cycle; stall chance in 256ths
// Plain walks without stall
1 00001000 0004 0040 0400 0004 0004 0004 00 00
1 00000000 0001 0010 0100 0010 0002 0001 00 00
1 20000000 0008 0000 0000 0003 0001 0001 00 00
1 00000100 0004 0020 0200 0001 0001 0001 00 00
1 00000000 0002 0003 0005 0001 0005 0003 00 00
1 00000000 8000 4000 2000 0002 0003 0004 00 00
// Walks under random stall
1 00000040 0004 0040 0400 0004 0004 0004 40 00
1 00008000 0010 0100 1000 0005 0003 0004 80 00
1 00000000 0001 0001 0001 0002 0002 0002 c0 00
1 00010000 0100 0001 0010 0003 0001 0006 20 00
// Large strides and bases that wrap past 32 bits
1 fffff000 ffff fff0 8000 0004 0003 0005 00 00
1 ffffff00 fffe ff00 c000 0003 0004 0002 60 00
1 fffffffc 0004 0000 0000 0008 0001 0001 00 00
1 80000000 ffff ffff ffff 0002 0002 0002 30 00
// Abort mid-run, then a fresh walk
2 00001000 0004 0040 0400 0004 0004 0004 00 0a
2 00002000 0008 0080 0800 0008 0004 0002 50 14
2 00003000 0004 0010 0100 0004 0004 0001 00 02
// Start while busy is ignored
3 00004000 0004 0040 0400 0004 0004 0002 00 08
3 00005000 0002 0020 0200 0003 0003 0003 40 10
3 fffffff0 0010 0100 1000 0004 0002 0002 00 05

// ==== all.f ====
+incdir+.
agu_pkg.sv
agu_if.sv
lib_counter.sv
agu_loop_nest.sv
agu_addr_sum.sv
agu_ctrl.sv
agu_top.sv
tb_agu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the AGU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    -f all.f --top-module tb_agu -o tb_agu \
    && ./obj_dir/tb_agu 2>&1 | tee sim.log \
    || echo "Build or run of the simulation did not complete"

grep -qx "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
